// ==== all.f ====
hw/rotator_pkg.sv
hw/bank_if.sv
hw/bank_writer.sv
hw/weight_bank.sv
hw/rotation_reader.sv
hw/loop_counters.sv
hw/skid_fifo.sv
hw/weight_rotator.sv
bench/tb_weight_rotator.sv

// ==== Bender.yml ====
package:
  name: weight_rotator

sources:
  - files:
      - hw/rotator_pkg.sv
      - hw/bank_if.sv
      - hw/bank_writer.sv
      - hw/weight_bank.sv
      - hw/rotation_reader.sv
      - hw/loop_counters.sv
      - hw/skid_fifo.sv
      - hw/weight_rotator.sv
  - target: test
    files:
      - bench/tb_weight_rotator.sv

// ==== bench/tb_weight_rotator.sv ====
// testbench for the weight rotator
// clock, reset, three random weight sets and random output back-pressure
// reference model of stored rows and nested loop positions
// checking by concurrent assertions, watchdog on the run length
`default_nettype none

module tb_weight_rotator;

  localparam int NSETS  = 3;
  localparam int ROW_W  = rotator_pkg::ROW_W;
  localparam int DEPTH  = rotator_pkg::DEPTH;
  localparam int ADDR_W = rotator_pkg::ADDR_W;
  localparam int KW2_W  = rotator_pkg::KW2_W;
  localparam int CI_W   = rotator_pkg::CI_W;
  localparam int XW_W   = rotator_pkg::XW_W;
  localparam int BLK_W  = rotator_pkg::BLK_W;
  localparam int XN_W   = rotator_pkg::XN_W;
  localparam int PAD_W  = ROW_W - rotator_pkg::CFG_W;

  logic             aclk;
  logic             aresetn;
  logic             i_s_valid;
  logic             o_s_ready;
  logic             i_s_last;
  logic [ROW_W-1:0] i_s_data;
  logic             o_m_valid;
  logic             i_m_ready;
  logic             o_m_last;
  logic [ROW_W-1:0] o_m_data;
  logic             o_m_w_first;
  logic             o_m_cin_last;
  logic             o_m_w_last;
  logic [KW2_W-1:0] o_m_kw2;

  integer seed = 32'h8bf0;

  // sets as sent, and the output position reached so far
  rotator_pkg::config_t set_cfg [NSETS];
  logic [ROW_W-1:0]     set_rows [NSETS][DEPTH];
  int                   set_total [NSETS];
  int                   total_beats = 0;
  int                   out_set;
  int                   out_beat;
  int                   sets_loaded;
  int                   sets_done;
  logic                 overlap_seen;
  logic                 sending_header;
  logic                 rst_d = 1'b0;
  logic [ROW_W-1:0]     exp_row;
  logic [2:0]           exp_flags;
  logic                 exp_last;
  logic [KW2_W-1:0]     exp_kw2;
  logic                 in_hs;
  logic                 out_hs;

  assign in_hs  = i_s_valid && o_s_ready;
  assign out_hs = o_m_valid && i_m_ready;

  weight_rotator dut0 (
    .aclk(aclk), .aresetn(aresetn),
    .i_s_valid(i_s_valid), .o_s_ready(o_s_ready), .i_s_last(i_s_last), .i_s_data(i_s_data),
    .o_m_valid(o_m_valid), .i_m_ready(i_m_ready), .o_m_last(o_m_last), .o_m_data(o_m_data),
    .o_m_w_first(o_m_w_first), .o_m_cin_last(o_m_cin_last), .o_m_w_last(o_m_w_last),
    .o_m_kw2(o_m_kw2)
  );

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first failed check");
  endtask

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // kernel * channels * columns * blocks * images beats per set
  function automatic int beat_count(input rotator_pkg::config_t c);
    return (2 * int'(c.kw2) + 1) * (int'(c.cin_1) + 1) * (int'(c.cols_1) + 1)
      * (int'(c.blocks_1) + 1) * (int'(c.xn_1) + 1);
  endfunction

  function automatic logic [ROW_W-1:0] expected_row(input int s, input int k);
    return set_rows[s][k % (int'(set_cfg[s].addr_max) + 1)];
  endfunction

  // {w_first, cin_last, w_last} from the beat index
  function automatic logic [2:0] expected_flags(input int s, input int k);
    int kn;
    int cn;
    int wn;
    int kp;
    int ch;
    int col;
    kn  = 2 * int'(set_cfg[s].kw2) + 1;
    cn  = int'(set_cfg[s].cin_1) + 1;
    wn  = int'(set_cfg[s].cols_1) + 1;
    kp  = k % kn;
    ch  = (k / kn) % cn;
    col = (k / (kn * cn)) % wn;
    return {(kp == 0) && (ch == 0) && (col == 0), (kp == kn - 1) && (ch == cn - 1),
            col == wn - 1};
  endfunction

  task automatic build_sets();
    for (int s = 0; s < NSETS; s++) begin
      set_cfg[s].kw2      = KW2_W'(pick(2));
      set_cfg[s].cin_1    = CI_W'(pick(3));
      set_cfg[s].cols_1   = XW_W'(pick(3));
      set_cfg[s].blocks_1 = BLK_W'(pick(2));
      set_cfg[s].xn_1     = XN_W'(pick(2));
      // middle set has a single row
      set_cfg[s].addr_max = (s == 1) ? '0 : ADDR_W'(1 + pick(9));
      for (int k = 0; k < DEPTH; k++) begin
        set_rows[s][k] = ROW_W'($random(seed));
      end
      set_total[s] = beat_count(set_cfg[s]);
      total_beats  = total_beats + set_total[s];
    end
  endtask

  // entered on a falling edge and left on the falling edge after the transfer
  task automatic send_beat(input logic [ROW_W-1:0] data, input logic last);
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    while (!o_s_ready) @(negedge aclk);
    @(negedge aclk);
  endtask

  task automatic send_set(input int s);
    rotator_pkg::beat_u beat;
    beat            = '0;
    beat.hdr.pad    = PAD_W'($random(seed));
    beat.hdr.cfg    = set_cfg[s];
    sending_header  = 1'b1;
    send_beat(beat, 1'b0);
    sending_header  = 1'b0;
    for (int k = 0; k <= int'(set_cfg[s].addr_max); k++) begin
      send_beat(set_rows[s][k], k == int'(set_cfg[s].addr_max));
    end
  endtask

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  initial begin
    i_m_ready = 1'b0;
    forever begin
      @(negedge aclk);
      i_m_ready = (pick(4) != 0);
    end
  end

  always @(posedge aclk) rst_d <= !aresetn;

  // output position model with expectations for the beat about to be shown
  always @(posedge aclk) begin : model_update
    int ns;
    int nk;
    if (!aresetn) begin
      ns = 0;
      nk = 0;
      sets_loaded  <= 0;
      sets_done    <= 0;
      overlap_seen <= 1'b0;
    end else begin
      ns = out_set;
      nk = out_beat;
      if (in_hs && !sending_header && i_s_last) sets_loaded <= sets_loaded + 1;
      if (in_hs && sending_header && (sets_loaded > sets_done)) overlap_seen <= 1'b1;
      if (out_hs && (out_set < NSETS)) begin
        if (out_beat == set_total[out_set] - 1) begin
          ns = out_set + 1;
          nk = 0;
          sets_done <= sets_done + 1;
        end else begin
          nk = out_beat + 1;
        end
      end
    end
    out_set  <= ns;
    out_beat <= nk;
    if (ns < NSETS) begin
      exp_row   <= expected_row(ns, nk);
      exp_flags <= expected_flags(ns, nk);
      exp_last  <= (nk == set_total[ns] - 1);
      exp_kw2   <= set_cfg[ns].kw2;
    end
  end

  a_reset_quiet: assert property (@(posedge aclk) rst_d |-> (!o_s_ready && !o_m_valid))
    else fail_run($sformatf("Error at %0t: ready or valid high around reset", $time));

  a_no_extra: assert property (@(posedge aclk) disable iff (!aresetn)
    out_hs |-> (out_set < NSETS))
    else fail_run($sformatf("Error at %0t: output beat after the last set", $time));

  a_row: assert property (@(posedge aclk) disable iff (!aresetn)
    out_hs |-> (o_m_data == exp_row))
    else fail_run($sformatf("Error at %0t: set %0d beat %0d data %h, expected %h",
      $time, $sampled(out_set), $sampled(out_beat), $sampled(o_m_data), $sampled(exp_row)));

  a_last: assert property (@(posedge aclk) disable iff (!aresetn)
    out_hs |-> (o_m_last == exp_last))
    else fail_run($sformatf("Error at %0t: set %0d beat %0d last %b, expected %b",
      $time, $sampled(out_set), $sampled(out_beat), $sampled(o_m_last), $sampled(exp_last)));

  a_flags: assert property (@(posedge aclk) disable iff (!aresetn)
    out_hs |-> (({o_m_w_first, o_m_cin_last, o_m_w_last} == exp_flags) && (o_m_kw2 == exp_kw2)))
    else fail_run($sformatf("Error at %0t: set %0d beat %0d flags %b kw2 %0d, expected %b %0d",
      $time, $sampled(out_set), $sampled(out_beat),
      $sampled({o_m_w_first, o_m_cin_last, o_m_w_last}), $sampled(o_m_kw2),
      $sampled(exp_flags), $sampled(exp_kw2)));

  // stalled beat holds everything
  a_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_data) && $stable(o_m_last)
      && $stable({o_m_w_first, o_m_cin_last, o_m_w_last, o_m_kw2})))
    else fail_run($sformatf("Error at %0t: stalled output beat changed", $time));

  a_ping_pong: assert property (@(posedge aclk) disable iff (!aresetn)
    ((sets_loaded - sets_done) >= 2) |-> !o_s_ready)
    else fail_run($sformatf("Error at %0t: input ready with both banks loaded", $time));

  initial begin : watchdog
    wait (total_beats > 0);
    repeat (40 * total_beats + 2000) @(posedge aclk);
    fail_run($sformatf("timeout: only %0d of %0d weight sets were played out",
      sets_done, NSETS));
  end

  initial begin : stimulus
    aresetn        = 1'b0;
    i_s_valid      = 1'b0;
    i_s_last       = 1'b0;
    i_s_data       = '0;
    sending_header = 1'b0;
    build_sets();
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    for (int s = 0; s < NSETS; s++) begin
      send_set(s);
    end
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    wait (sets_done == NSETS);
    // a few idle cycles so a stray beat still trips a check
    repeat (6) @(negedge aclk);
    if (!overlap_seen) begin
      fail_run("no set was loaded while another set was still being played out");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== hw/weight_rotator.sv ====
// weight_rotator: top level of the weight rotator
// writer, ping-pong banks, reader, loop counters and output FIFO
`default_nettype none

module weight_rotator #(
  parameter int COLS          = rotator_pkg::COLS,
  parameter int WORD_W        = rotator_pkg::WORD_W,
  parameter int DEPTH         = rotator_pkg::DEPTH,
  parameter int RAM_LATENCY   = rotator_pkg::RAM_LATENCY,
  parameter int KW_MAX        = rotator_pkg::KW_MAX,
  parameter int CI_MAX        = rotator_pkg::CI_MAX,
  parameter int XW_MAX        = rotator_pkg::XW_MAX,
  parameter int XH_BLOCKS_MAX = rotator_pkg::XH_BLOCKS_MAX,
  parameter int XN_MAX        = rotator_pkg::XN_MAX,
  localparam int ROW_W  = COLS * WORD_W,
  localparam int ADDR_W = $clog2(DEPTH),
  localparam int CNT_W  = $clog2(2 * RAM_LATENCY + 1)
) (
  input  wire                           aclk,
  input  wire                           aresetn,
  input  wire                           i_s_valid,
  output logic                          o_s_ready,
  input  wire                           i_s_last,
  input  wire [ROW_W-1:0]               i_s_data,
  output logic                          o_m_valid,
  input  wire                           i_m_ready,
  output logic                          o_m_last,
  output logic [ROW_W-1:0]              o_m_data,
  output logic                          o_m_w_first,
  output logic                          o_m_cin_last,
  output logic                          o_m_w_last,
  output logic [rotator_pkg::KW2_W-1:0] o_m_kw2
);

  logic [1:0]       full;
  logic             release_pulse;
  logic             release_bank;
  logic             push;
  logic             clear;
  logic             pop;
  logic [CNT_W-1:0] fifo_count;

  bank_wr_if #(.ROW_W(ROW_W), .ADDR_W(ADDR_W)) wr_bus ();
  bank_rd_if #(.ROW_W(ROW_W), .ADDR_W(ADDR_W)) rd_bus ();

  // one output transfer
  assign pop = o_m_valid && i_m_ready;

  bank_writer #(.ROW_W(ROW_W), .DEPTH(DEPTH)) u_writer (
    .aclk(aclk), .aresetn(aresetn),
    .i_s_valid(i_s_valid), .i_s_last(i_s_last), .i_s_data(i_s_data),
    .i_release(release_pulse), .i_release_bank(release_bank),
    .o_s_ready(o_s_ready), .o_full(full), .wr(wr_bus.writer)
  );

  weight_bank #(.ROW_W(ROW_W), .DEPTH(DEPTH), .RAM_LATENCY(RAM_LATENCY)) u_bank (
    .aclk(aclk), .aresetn(aresetn), .wr(wr_bus.memory), .rd(rd_bus.memory)
  );

  rotation_reader #(.DEPTH(DEPTH), .RAM_LATENCY(RAM_LATENCY)) u_reader (
    .aclk(aclk), .aresetn(aresetn),
    .i_full(full), .i_pop(pop), .i_fifo_count(fifo_count), .i_last_beat(o_m_last),
    .o_release(release_pulse), .o_release_bank(release_bank),
    .o_push(push), .o_clear(clear), .rd(rd_bus.master)
  );

  loop_counters #(
    .KW_MAX(KW_MAX), .CI_MAX(CI_MAX), .XW_MAX(XW_MAX),
    .XH_BLOCKS_MAX(XH_BLOCKS_MAX), .XN_MAX(XN_MAX)
  ) u_counters (
    .aclk(aclk), .aresetn(aresetn),
    .i_clear(clear), .i_step(pop), .i_cfg(rd_bus.rd_cfg),
    .o_last(o_m_last), .o_w_first(o_m_w_first), .o_cin_last(o_m_cin_last),
    .o_w_last(o_m_w_last), .o_kw2(o_m_kw2)
  );

  skid_fifo #(.ROW_W(ROW_W), .RAM_LATENCY(RAM_LATENCY)) u_fifo (
    .aclk(aclk), .aresetn(aresetn),
    .i_flush(release_pulse), .i_push(push), .i_row(rd_bus.rd_row), .i_ready(i_m_ready),
    .o_valid(o_m_valid), .o_row(o_m_data), .o_count(fifo_count)
  );

endmodule

`default_nettype wire

// ==== hw/skid_fifo.sv ====
// skid_fifo: register FIFO of 2*RAM_LATENCY rows
// holds prefetched rows while the output is stalled
`default_nettype none

module skid_fifo #(
  parameter int ROW_W       = rotator_pkg::ROW_W,
  parameter int RAM_LATENCY = rotator_pkg::RAM_LATENCY,
  localparam int FIFO_DEPTH = 2 * RAM_LATENCY,
  localparam int PTR_W      = $clog2(FIFO_DEPTH),
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  wire              aclk,
  input  wire              aresetn,
  input  wire              i_flush,
  input  wire              i_push,
  input  wire [ROW_W-1:0]  i_row,
  input  wire              i_ready,
  output logic             o_valid,
  output logic [ROW_W-1:0] o_row,
  output logic [CNT_W-1:0] o_count
);

  logic [ROW_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign o_valid = (count != '0);
  assign o_row   = mem[rd_ptr];
  assign o_count = count;
  assign pop     = o_valid && i_ready;

  always_ff @(posedge aclk) begin
    if (i_push) mem[wr_ptr] <= i_row;
  end

  // flush wins over push and pop
  always_ff @(posedge aclk) begin
    if (!aresetn || i_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= ptr_next(wr_ptr);
      if (pop) rd_ptr <= ptr_next(rd_ptr);
      count <= count + CNT_W'(i_push) - CNT_W'(pop);
    end
  end

  a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
    (i_push && !i_flush) |-> (count < FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== hw/loop_counters.sv ====
// loop_counters: five chained wrap counters for one weight set
// kernel, channel, column, block and image positions
// end marker and position flags of the current output beat
`default_nettype none

module loop_counters #(
  parameter int KW_MAX        = rotator_pkg::KW_MAX,
  parameter int CI_MAX        = rotator_pkg::CI_MAX,
  parameter int XW_MAX        = rotator_pkg::XW_MAX,
  parameter int XH_BLOCKS_MAX = rotator_pkg::XH_BLOCKS_MAX,
  parameter int XN_MAX        = rotator_pkg::XN_MAX,
  localparam int LIM_A = (KW_MAX > CI_MAX) ? KW_MAX : CI_MAX,
  localparam int LIM_B = (LIM_A > XW_MAX) ? LIM_A : XW_MAX,
  localparam int LIM_C = (LIM_B > XH_BLOCKS_MAX) ? LIM_B : XH_BLOCKS_MAX,
  localparam int LIM_D = (LIM_C > XN_MAX) ? LIM_C : XN_MAX,
  localparam int CW    = $clog2(LIM_D)
) (
  input  wire                           aclk,
  input  wire                           aresetn,
  input  wire                           i_clear,
  input  wire                           i_step,
  input  wire rotator_pkg::config_t     i_cfg,
  output logic                          o_last,
  output logic                          o_w_first,
  output logic                          o_cin_last,
  output logic                          o_w_last,
  output logic [rotator_pkg::KW2_W-1:0] o_kw2
);

  // stage 0 innermost: kernel, channel, column, block, image
  logic [4:0][CW-1:0] cnt_q;
  logic [4:0][CW-1:0] lim;
  logic [4:0]         at_max;
  logic [4:0]         carry;

  assign lim[0] = CW'({i_cfg.kw2, 1'b0});
  assign lim[1] = CW'(i_cfg.cin_1);
  assign lim[2] = CW'(i_cfg.cols_1);
  assign lim[3] = CW'(i_cfg.blocks_1);
  assign lim[4] = CW'(i_cfg.xn_1);

  always_comb begin
    for (int i = 0; i < 5; i++) begin
      at_max[i] = (cnt_q[i] == lim[i]);
    end
    carry[0] = i_step;
    for (int i = 1; i < 5; i++) begin
      carry[i] = carry[i-1] && at_max[i-1];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn || i_clear) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < 5; i++) begin
        if (carry[i]) cnt_q[i] <= at_max[i] ? '0 : cnt_q[i] + 1'b1;
      end
    end
  end

  assign o_w_first  = (cnt_q[0] == '0) && (cnt_q[1] == '0) && (cnt_q[2] == '0);
  assign o_cin_last = at_max[0] && at_max[1];
  assign o_w_last   = at_max[2];
  assign o_last     = &at_max;
  assign o_kw2      = i_cfg.kw2;

endmodule

`default_nettype wire

// ==== hw/rotation_reader.sv ====
// rotation_reader: read FSM for the full bank
// cyclic row addressing, prefetch credit against the output FIFO
// bank release and FIFO flush after the final beat
`default_nettype none

module rotation_reader #(
  parameter int DEPTH       = rotator_pkg::DEPTH,
  parameter int RAM_LATENCY = rotator_pkg::RAM_LATENCY,
  localparam int ADDR_W     = $clog2(DEPTH),
  localparam int FIFO_DEPTH = 2 * RAM_LATENCY,
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  wire              aclk,
  input  wire              aresetn,
  input  wire [1:0]        i_full,
  input  wire              i_pop,
  input  wire [CNT_W-1:0]  i_fifo_count,
  input  wire              i_last_beat,
  output logic             o_release,
  output logic             o_release_bank,
  output logic             o_push,
  output logic             o_clear,
  bank_rd_if.master        rd
);

  typedef enum logic {R_IDLE, R_READ} r_state_e;

  r_state_e               state;
  logic                   bank_q;
  logic [ADDR_W-1:0]      addr_q;
  // one bit per outstanding read, aligned with the bank latency
  logic [RAM_LATENCY-1:0] pend_q;
  logic [CNT_W:0]         in_flight;
  logic                   issue;

  always_comb begin
    in_flight = '0;
    for (int i = 0; i < RAM_LATENCY; i++) begin
      in_flight = in_flight + (CNT_W + 1)'(pend_q[i]);
    end
  end

  // reads in flight plus buffered rows may not exceed the FIFO
  assign issue     = (state == R_READ) && ((in_flight + i_fifo_count) < FIFO_DEPTH);
  assign o_clear   = (state == R_IDLE) && i_full[bank_q];
  assign o_release = (state == R_READ) && i_pop && i_last_beat;
  assign o_release_bank = bank_q;
  assign o_push    = rd.rd_valid && pend_q[RAM_LATENCY-1];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state  <= R_IDLE;
      bank_q <= 1'b0;
      addr_q <= '0;
    end else begin
      case (state)
        R_IDLE: begin
          if (o_clear) begin
            addr_q <= '0;
            state  <= R_READ;
          end
        end
        R_READ: begin
          if (o_release) begin
            bank_q <= ~bank_q;
            state  <= R_IDLE;
          end else if (issue) begin
            addr_q <= (addr_q == rd.rd_cfg.addr_max) ? '0 : addr_q + 1'b1;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  // late returns of a finished set are dropped here
  always_ff @(posedge aclk) begin
    if (!aresetn || o_release) begin
      pend_q <= '0;
    end else begin
      pend_q <= RAM_LATENCY'({pend_q, issue});
    end
  end

  assign rd.rd_en   = issue;
  assign rd.rd_bank = bank_q;
  assign rd.rd_addr = addr_q;

  a_release_full: assert property (@(posedge aclk) disable iff (!aresetn)
    o_release |-> i_full[o_release_bank]);

endmodule

`default_nettype wire

// ==== hw/weight_bank.sv ====
// weight_bank: two row banks with a config register each
// read data and valid delayed by RAM_LATENCY cycles
`default_nettype none

module weight_bank #(
  parameter int ROW_W       = rotator_pkg::ROW_W,
  parameter int DEPTH       = rotator_pkg::DEPTH,
  parameter int RAM_LATENCY = rotator_pkg::RAM_LATENCY
) (
  input  wire        aclk,
  input  wire        aresetn,
  bank_wr_if.memory  wr,
  bank_rd_if.memory  rd
);

  logic [ROW_W-1:0]     mem [2][DEPTH];
  rotator_pkg::config_t cfg_q [2];
  rotator_pkg::beat_u   wr_beat;
  logic [ROW_W-1:0]     row_pipe [RAM_LATENCY];
  logic [RAM_LATENCY-1:0] vld_pipe;

  assign wr_beat = wr.wr_row;

  always_ff @(posedge aclk) begin
    if (wr.wr_en) mem[wr.wr_bank][wr.wr_addr] <= wr.wr_row;
    if (wr.cfg_en) cfg_q[wr.wr_bank] <= wr_beat.hdr.cfg;
  end

  // first stage is the array read, the rest are output registers
  always_ff @(posedge aclk) begin
    if (rd.rd_en) row_pipe[0] <= mem[rd.rd_bank][rd.rd_addr];
    for (int i = 1; i < RAM_LATENCY; i++) begin
      row_pipe[i] <= row_pipe[i-1];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= RAM_LATENCY'({vld_pipe, rd.rd_en});
    end
  end

  assign rd.rd_valid = vld_pipe[RAM_LATENCY-1];
  assign rd.rd_row   = row_pipe[RAM_LATENCY-1];
  assign rd.rd_cfg   = cfg_q[rd.rd_bank];

  // writer and reader never share a bank
  a_no_bank_clash: assert property (@(posedge aclk) disable iff (!aresetn)
    !(wr.wr_en && rd.rd_en && (wr.wr_bank == rd.rd_bank)));

endmodule

`default_nettype wire

// ==== hw/bank_writer.sv ====
// bank_writer: input stream FSM for weight sets
// header capture, row writes, bank toggle and bank-full flags
`default_nettype none

module bank_writer #(
  parameter int ROW_W = rotator_pkg::ROW_W,
  parameter int DEPTH = rotator_pkg::DEPTH,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  wire              aclk,
  input  wire              aresetn,
  input  wire              i_s_valid,
  input  wire              i_s_last,
  input  wire [ROW_W-1:0]  i_s_data,
  input  wire              i_release,
  input  wire              i_release_bank,
  output logic             o_s_ready,
  output logic [1:0]       o_full,
  bank_wr_if.writer        wr
);

  typedef enum logic [2:0] {W_IDLE, W_HEADER, W_WRITE, W_FINISH, W_SWITCH} w_state_e;

  w_state_e           state;
  logic               bank_q;
  // one extra bit so an overlong set shows up
  logic [ADDR_W:0]    addr_q;
  logic [1:0]         full_q;
  rotator_pkg::beat_u beat;
  logic               s_hs;
  logic               hdr_hs;
  logic               row_hs;

  assign beat      = i_s_data;
  assign o_s_ready = (state == W_HEADER) || (state == W_WRITE);
  assign s_hs      = i_s_valid && o_s_ready;
  assign hdr_hs    = s_hs && (state == W_HEADER);
  assign row_hs    = s_hs && (state == W_WRITE);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state  <= W_IDLE;
      bank_q <= 1'b0;
      addr_q <= '0;
    end else begin
      case (state)
        W_IDLE: begin
          if (!full_q[bank_q]) state <= W_HEADER;
        end
        W_HEADER: begin
          if (hdr_hs) begin
            addr_q <= '0;
            state  <= W_WRITE;
          end
        end
        W_WRITE: begin
          if (row_hs) begin
            addr_q <= addr_q + 1'b1;
            if (i_s_last) state <= W_FINISH;
          end
        end
        W_FINISH: state <= W_SWITCH;
        W_SWITCH: begin
          bank_q <= ~bank_q;
          // skip idle when the other bank is already free
          state  <= full_q[~bank_q] ? W_IDLE : W_HEADER;
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  // set on the last row, cleared by the reader's release
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      full_q <= 2'b00;
    end else begin
      if (i_release) full_q[i_release_bank] <= 1'b0;
      if (row_hs && i_s_last) full_q[bank_q] <= 1'b1;
    end
  end

  assign o_full     = full_q;
  assign wr.wr_en   = row_hs;
  assign wr.cfg_en  = hdr_hs;
  assign wr.wr_bank = bank_q;
  assign wr.wr_addr = addr_q[ADDR_W-1:0];
  // header beat keeps only the config fields
  assign wr.wr_row  = hdr_hs ? ROW_W'(beat.hdr.cfg) : beat.row;

  a_wr_addr_range: assert property (@(posedge aclk) disable iff (!aresetn)
    wr.wr_en |-> (addr_q < DEPTH));

endmodule

`default_nettype wire

// ==== hw/bank_if.sv ====
// bank_wr_if: row and header writes into the two banks
// bank_rd_if: read requests, delayed read data and bank config
`default_nettype none

interface bank_wr_if #(
  parameter int ROW_W  = rotator_pkg::ROW_W,
  parameter int ADDR_W = rotator_pkg::ADDR_W
);
  logic              wr_en;
  logic              wr_bank;
  logic [ADDR_W-1:0] wr_addr;
  logic [ROW_W-1:0]  wr_row;
  // header beat rides on wr_row
  logic              cfg_en;

  modport writer (output wr_en, wr_bank, wr_addr, wr_row, cfg_en);
  modport memory (input wr_en, wr_bank, wr_addr, wr_row, cfg_en);
endinterface

interface bank_rd_if #(
  parameter int ROW_W  = rotator_pkg::ROW_W,
  parameter int ADDR_W = rotator_pkg::ADDR_W
);
  logic                 rd_en;
  logic                 rd_bank;
  logic [ADDR_W-1:0]    rd_addr;
  logic                 rd_valid;
  logic [ROW_W-1:0]     rd_row;
  rotator_pkg::config_t rd_cfg;

  modport master (output rd_en, rd_bank, rd_addr, input rd_valid, rd_row, rd_cfg);
  modport memory (input rd_en, rd_bank, rd_addr, output rd_valid, rd_row, rd_cfg);
endinterface

`default_nettype wire

// ==== hw/rotator_pkg.sv ====
// shared sizes for the weight rotator
// loop limits and derived field widths
// header config fields and the header/row beat union
`default_nettype none

package rotator_pkg;

  localparam int COLS          = 4;
  localparam int WORD_W        = 8;
  localparam int ROW_W         = COLS * WORD_W;
  localparam int DEPTH         = 64;
  localparam int RAM_LATENCY   = 2;

  // loop limits, kernel width is odd
  localparam int KW_MAX        = 7;
  localparam int CI_MAX        = 8;
  localparam int XW_MAX        = 16;
  localparam int XH_BLOCKS_MAX = 4;
  localparam int XN_MAX        = 2;

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int KW2_W  = $clog2((KW_MAX + 1) / 2);
  localparam int CI_W   = $clog2(CI_MAX);
  localparam int XW_W   = $clog2(XW_MAX);
  localparam int BLK_W  = $clog2(XH_BLOCKS_MAX);
  localparam int XN_W   = $clog2(XN_MAX);

  // header fields, all counts stored minus one except kw2
  typedef struct packed {
    logic [ADDR_W-1:0] addr_max;
    logic [XN_W-1:0]   xn_1;
    logic [BLK_W-1:0]  blocks_1;
    logic [XW_W-1:0]   cols_1;
    logic [CI_W-1:0]   cin_1;
    logic [KW2_W-1:0]  kw2;
  } config_t;

  localparam int CFG_W = $bits(config_t);

  typedef struct packed {
    logic [ROW_W-CFG_W-1:0] pad;
    config_t                cfg;
  } header_t;

  // one input word, either a set header or a weight row
  typedef union packed {
    header_t                      hdr;
    logic [COLS-1:0][WORD_W-1:0]  row;
  } beat_u;

endpackage

`default_nettype wire
